// ==== Bender.yml ====
package:
  name: soc_tcm

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - soc_pkg.sv
      - ahb_if.sv
      - ahb_decoder.sv
      - ahb_to_sram.sv
      - tcm_ram.sv
      - soc.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_soc.sv

// ==== ahb_decoder.sv ====
`include "soc_defines.svh"

module ahb_decoder
    import soc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] haddr,
    input  logic [1:0]  htrans,
    input  logic        hwrite,
    input  logic [2:0]  hsize,
    input  logic [31:0] hwdata,
    output logic [31:0] hrdata,
    output logic        hready,
    output logic        hresp,
    ahb_if.manager      itcm_bus,
    ahb_if.manager      dtcm_bus
);

    ahb_addr_u addr;
    logic      active;
    logic      hit_itcm;
    logic      hit_dtcm;
    logic      dsel_itcm;
    logic      dsel_dtcm;
    logic      err_first;
    logic      err_second;

    assign addr     = haddr;
    assign active   = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);
    assign hit_itcm = addr.region_view.region == `SOC_REGION_ITCM;
    assign hit_dtcm = addr.region_view.region == `SOC_REGION_DTCM;

    // Address phase fans out to both TCMs, only hsel differs
    assign itcm_bus.hsel   = hit_itcm;
    assign itcm_bus.haddr  = addr;
    assign itcm_bus.htrans = htrans_e'(htrans);
    assign itcm_bus.hwrite = hwrite;
    assign itcm_bus.hsize  = hsize_e'(hsize);
    assign itcm_bus.hwdata = hwdata;
    assign itcm_bus.hready = hready;

    assign dtcm_bus.hsel   = hit_dtcm;
    assign dtcm_bus.haddr  = addr;
    assign dtcm_bus.htrans = htrans_e'(htrans);
    assign dtcm_bus.hwrite = hwrite;
    assign dtcm_bus.hsize  = hsize_e'(hsize);
    assign dtcm_bus.hwdata = hwdata;
    assign dtcm_bus.hready = hready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dsel_itcm  <= 1'b0;
            dsel_dtcm  <= 1'b0;
            err_first  <= 1'b0;
            err_second <= 1'b0;
        end else begin
            // Unmapped transfer: first error cycle stalls, second one releases
            err_first  <= hready && active && !hit_itcm && !hit_dtcm;
            err_second <= err_first;
            if (hready) begin
                dsel_itcm <= active && hit_itcm;
                dsel_dtcm <= active && hit_dtcm;
            end
        end
    end

    // Response mux, idle data phase answers OKAY with zero data
    always_comb begin
        hrdata = 32'h0;
        hready = 1'b1;
        hresp  = 1'b0;
        if (dsel_itcm) begin
            hrdata = itcm_bus.hrdata;
            hready = itcm_bus.hreadyout;
            hresp  = itcm_bus.hresp;
        end else if (dsel_dtcm) begin
            hrdata = dtcm_bus.hrdata;
            hready = dtcm_bus.hreadyout;
            hresp  = dtcm_bus.hresp;
        end else if (err_first) begin
            hready = 1'b0;
            hresp  = 1'b1;
        end else if (err_second) begin
            hresp  = 1'b1;
        end
    end

endmodule

// ==== ahb_if.sv ====
interface ahb_if
    import soc_pkg::*;
();

    logic        hsel;
    ahb_addr_u   haddr;
    htrans_e     htrans;
    logic        hwrite;
    hsize_e      hsize;
    logic [31:0] hwdata;
    logic        hready;
    logic        hreadyout;
    logic        hresp;
    logic [31:0] hrdata;

    modport manager (
        output hsel,
        output haddr,
        output htrans,
        output hwrite,
        output hsize,
        output hwdata,
        output hready,
        input  hreadyout,
        input  hresp,
        input  hrdata
    );

    modport subordinate (
        input  hsel,
        input  haddr,
        input  htrans,
        input  hwrite,
        input  hsize,
        input  hwdata,
        input  hready,
        output hreadyout,
        output hresp,
        output hrdata
    );

endinterface

// ==== ahb_to_sram.sv ====
module ahb_to_sram
    import soc_pkg::*;
#(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                  clk,
    input  logic                  rst_n,
    ahb_if.subordinate            bus,
    output logic                  ram_cs,
    output logic [ADDR_WIDTH-1:0] ram_addr,
    output logic [3:0]            ram_be,
    output logic [31:0]           ram_wdata,
    input  logic [31:0]           ram_rdata
);

    logic                  active;
    logic                  rd_req;
    logic                  wr_req;
    logic [ADDR_WIDTH-1:0] index;
    logic [3:0]            lane_be;
    logic                  rd_dphase;
    logic [ADDR_WIDTH-1:0] rd_addr_q;
    logic                  wr_dphase;
    logic [ADDR_WIDTH-1:0] wr_addr_q;
    logic [3:0]            wr_be_q;
    logic                  wr_done;
    logic                  wr_direct;
    logic                  buf_valid;
    logic                  buf_commit;
    logic [ADDR_WIDTH-1:0] buf_addr;
    logic [3:0]            buf_be;
    logic [31:0]           buf_data;
    logic                  fwd_hit;

    assign active = bus.hsel && bus.hready &&
                    (bus.htrans == HTRANS_NONSEQ || bus.htrans == HTRANS_SEQ);
    assign rd_req = active && !bus.hwrite;
    assign wr_req = active && bus.hwrite;
    assign index  = bus.haddr.word_view.index[ADDR_WIDTH-1:0];

    always_comb begin
        case (bus.hsize)
            HSIZE_BYTE: lane_be = 4'b0001 << bus.haddr.word_view.byte_off;
            HSIZE_HALF: lane_be = bus.haddr.word_view.byte_off[1] ? 4'b1100 : 4'b0011;
            default:    lane_be = 4'b1111;
        endcase
    end

    // A write whose data phase shares the cycle with a read goes to the buffer,
    // otherwise it is written straight through
    assign wr_done    = wr_dphase && bus.hready;
    assign buf_commit = buf_valid && !rd_req;
    assign wr_direct  = wr_done && !rd_req && !buf_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_dphase <= 1'b0;
            wr_dphase <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            if (bus.hready) begin
                rd_dphase <= rd_req;
                wr_dphase <= wr_req;
            end
            if (wr_done && !wr_direct) begin
                buf_valid <= 1'b1;
            end else if (buf_commit) begin
                buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            rd_addr_q <= index;
        end
        if (wr_req) begin
            wr_addr_q <= index;
            wr_be_q   <= lane_be;
        end
        if (wr_done && !wr_direct) begin
            buf_addr <= wr_addr_q;
            buf_be   <= wr_be_q;
            buf_data <= bus.hwdata;
        end
    end

    // Reads own the port; pending writes use it otherwise
    always_comb begin
        ram_cs    = rd_req || buf_commit || wr_direct;
        ram_addr  = index;
        ram_be    = 4'b0000;
        ram_wdata = bus.hwdata;
        if (buf_commit) begin
            ram_addr  = buf_addr;
            ram_be    = buf_be;
            ram_wdata = buf_data;
        end else if (wr_direct) begin
            ram_addr  = wr_addr_q;
            ram_be    = wr_be_q;
        end
    end

    assign fwd_hit = rd_dphase && buf_valid && (buf_addr == rd_addr_q);

    // Buffered bytes override stale RAM data
    always_comb begin
        bus.hrdata = ram_rdata;
        if (fwd_hit) begin
            for (int i = 0; i < 4; i++) begin
                if (buf_be[i]) begin
                    bus.hrdata[8*i +: 8] = buf_data[8*i +: 8];
                end
            end
        end
    end

    assign bus.hreadyout = 1'b1;
    assign bus.hresp     = 1'b0;

endmodule

// ==== compile.f ====
+incdir+.
soc_pkg.sv
ahb_if.sv
ahb_decoder.sv
ahb_to_sram.sv
tcm_ram.sv
soc.sv
tb_soc.sv

// ==== soc.sv ====
`include "soc_defines.svh"

module soc (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] haddr,
    input  logic [1:0]  htrans,
    input  logic        hwrite,
    input  logic [2:0]  hsize,
    input  logic [31:0] hwdata,
    output logic [31:0] hrdata,
    output logic        hready,
    output logic        hresp
);

    ahb_if itcm_bus ();
    ahb_if dtcm_bus ();

    logic                    itcm_cs;
    logic [`SOC_ITCM_AW-1:0] itcm_addr;
    logic [3:0]              itcm_be;
    logic [31:0]             itcm_wdata;
    logic [31:0]             itcm_rdata;

    logic                    dtcm_cs;
    logic [`SOC_DTCM_AW-1:0] dtcm_addr;
    logic [3:0]              dtcm_be;
    logic [31:0]             dtcm_wdata;
    logic [31:0]             dtcm_rdata;

    ahb_decoder u_ahb_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .haddr    (haddr),
        .htrans   (htrans),
        .hwrite   (hwrite),
        .hsize    (hsize),
        .hwdata   (hwdata),
        .hrdata   (hrdata),
        .hready   (hready),
        .hresp    (hresp),
        .itcm_bus (itcm_bus),
        .dtcm_bus (dtcm_bus)
    );

    ahb_to_sram #(.ADDR_WIDTH(`SOC_ITCM_AW)) u_ahb_itcm (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (itcm_bus),
        .ram_cs    (itcm_cs),
        .ram_addr  (itcm_addr),
        .ram_be    (itcm_be),
        .ram_wdata (itcm_wdata),
        .ram_rdata (itcm_rdata)
    );

    tcm_ram #(.WORDS(`SOC_ITCM_WORDS)) u_itcm (
        .clk   (clk),
        .cs    (itcm_cs),
        .addr  (itcm_addr),
        .be    (itcm_be),
        .wdata (itcm_wdata),
        .rdata (itcm_rdata)
    );

    ahb_to_sram #(.ADDR_WIDTH(`SOC_DTCM_AW)) u_ahb_dtcm (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (dtcm_bus),
        .ram_cs    (dtcm_cs),
        .ram_addr  (dtcm_addr),
        .ram_be    (dtcm_be),
        .ram_wdata (dtcm_wdata),
        .ram_rdata (dtcm_rdata)
    );

    tcm_ram #(.WORDS(`SOC_DTCM_WORDS)) u_dtcm (
        .clk   (clk),
        .cs    (dtcm_cs),
        .addr  (dtcm_addr),
        .be    (dtcm_be),
        .wdata (dtcm_wdata),
        .rdata (dtcm_rdata)
    );

endmodule

// ==== soc_defines.svh ====
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Memory map
`define SOC_ITCM_BASE 32'h0000_0000
`define SOC_DTCM_BASE 32'h2000_0000

// Region codes from HADDR[31:28]
`define SOC_REGION_ITCM 4'h0
`define SOC_REGION_DTCM 4'h2

// TCM depth in 32-bit words
`define SOC_ITCM_WORDS 4096
`define SOC_DTCM_WORDS 2048

// Word index widths
`define SOC_ITCM_AW 12
`define SOC_DTCM_AW 11

`endif

// ==== soc_pkg.sv ====
package soc_pkg;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        HSIZE_BYTE = 3'b000,
        HSIZE_HALF = 3'b001,
        HSIZE_WORD = 3'b010
    } hsize_e;

    // One HADDR, decoded by region in the decoder and by word in the bridges
    typedef union packed {
        struct packed {
            logic [3:0]  region;
            logic [27:0] offset;
        } region_view;
        struct packed {
            logic [15:0] upper;
            logic [13:0] index;
            logic [1:0]  byte_off;
        } word_view;
    } ahb_addr_u;

endpackage

// ==== tb_soc.sv ====
module tb_soc
    import soc_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS = 6;
    localparam int TIMEOUT   = 20;

    typedef enum logic [1:0] {K_IDLE, K_WRITE, K_READ} kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [31:0] addr;
        hsize_e      size;
        logic [31:0] data;
        logic        err;
        logic [3:0]  test;
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] haddr;
    logic [1:0]  htrans;
    logic        hwrite;
    logic [2:0]  hsize;
    logic [31:0] hwdata;
    logic [31:0] hrdata;
    logic        hready;
    logic        hresp;

    entry_t      table_q [$];
    entry_t      dp;
    logic [7:0]  ref_mem [logic [31:0]];
    integer      seed;
    int          test_errs [NUM_TESTS + 1];
    int          tests_passed;
    int          tests_failed;
    string       test_names [NUM_TESTS + 1] = '{"reset values", "word write and read",
        "byte and halfword merge", "write buffer forwarding", "unmapped error",
        "itcm dtcm independence", "flush"};

    soc dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .haddr  (haddr),
        .htrans (htrans),
        .hwrite (hwrite),
        .hsize  (hsize),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hready (hready),
        .hresp  (hresp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic entry_t make_entry(input kind_e kind, input logic [31:0] addr,
                                          input hsize_e size, input logic [31:0] data,
                                          input logic err, input int test);
        entry_t e;
        e.kind = kind;
        e.addr = addr;
        e.size = size;
        e.data = data;
        e.err  = err;
        e.test = test[3:0];
        return e;
    endfunction

    task automatic add(input kind_e kind, input logic [31:0] addr, input hsize_e size,
                       input logic [31:0] data, input logic err, input int test);
        table_q.push_back(make_entry(kind, addr, size, data, err, test));
    endtask

    // Reference memory, one entry per byte address
    task automatic model_write(input logic [31:0] addr, input hsize_e size,
                               input logic [31:0] data);
        int          nbytes;
        logic [31:0] first;
        logic [31:0] a;
        nbytes = 1 << size;
        first  = addr & ~(nbytes - 1);
        for (int b = 0; b < nbytes; b++) begin
            a = first + b;
            ref_mem[a] = data[8*a[1:0] +: 8];
        end
    endtask

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        logic [31:0] word;
        logic [31:0] base;
        word = 32'h0;
        base = {addr[31:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            if (ref_mem.exists(base + i)) begin
                word[8*i +: 8] = ref_mem[base + i];
            end
        end
        return word;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act, input int test);
        $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
        test_errs[test]++;
    endtask

    task automatic report_test(input int t);
        if (test_errs[t] == 0) begin
            $display("Test %0d (%s) passed", t, test_names[t]);
            tests_passed++;
        end else begin
            $display("Test %0d (%s) failed with %0d errors", t, test_names[t], test_errs[t]);
            tests_failed++;
        end
    endtask

    // Response of the transfer now in its data phase, sampled mid-cycle
    task automatic check_response(input int cycle);
        logic [31:0] exp;
        if (dp.err) begin
            if (hready !== (cycle >= 2)) report_mismatch("hready", cycle >= 2, hready, dp.test);
            if (hresp !== 1'b1) report_mismatch("hresp", 1'b1, hresp, dp.test);
        end else begin
            if (hready !== 1'b1) report_mismatch("hready", 1'b1, hready, dp.test);
            if (hresp !== 1'b0) report_mismatch("hresp", 1'b0, hresp, dp.test);
            if (dp.kind == K_READ) begin
                exp = model_read(dp.addr);
                if (hrdata !== exp) report_mismatch("hrdata", exp, hrdata, dp.test);
            end
        end
    endtask

    // Address phase of e overlaps the data phase of dp
    task automatic issue(input entry_t e);
        int cycles;
        int expected;
        cycles   = 1;
        expected = dp.err ? 2 : 1;
        check_response(cycles);
        haddr  = e.addr;
        htrans = (e.kind == K_IDLE) ? HTRANS_IDLE : HTRANS_NONSEQ;
        // Idle entries keep hwrite high, so only htrans stops a write
        hwrite = (e.kind != K_READ);
        hsize  = e.size;
        hwdata = (dp.kind == K_WRITE) ? dp.data : 32'h0;
        while (hready !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout: hready stayed low for %0d cycles at address %h",
                         cycles, dp.addr);
                $display("Simulation finished: FAIL");
                $finish;
            end
            check_response(cycles);
        end
        if (cycles != expected) begin
            $display("Data phase at address %h took %0d cycles instead of %0d",
                     dp.addr, cycles, expected);
            test_errs[dp.test]++;
        end
        if (dp.kind == K_WRITE && !dp.err) begin
            model_write(dp.addr, dp.size, dp.data);
        end
        if (dp.test != e.test) begin
            report_test(dp.test);
        end
        dp = e;
        @(negedge clk);
    endtask

    task automatic build_table();
        add(K_WRITE, 32'h0000_0010, HSIZE_WORD, $random(seed), 1'b0, 1);
        add(K_WRITE, 32'h0000_3ffc, HSIZE_WORD, $random(seed), 1'b0, 1);
        add(K_WRITE, 32'h2000_0040, HSIZE_WORD, $random(seed), 1'b0, 1);
        add(K_WRITE, 32'h2000_1ffc, HSIZE_WORD, $random(seed), 1'b0, 1);
        add(K_READ,  32'h0000_0010, HSIZE_WORD, 32'h0, 1'b0, 1);
        add(K_READ,  32'h2000_1ffc, HSIZE_WORD, 32'h0, 1'b0, 1);
        add(K_READ,  32'h0000_3ffc, HSIZE_WORD, 32'h0, 1'b0, 1);
        add(K_READ,  32'h2000_0040, HSIZE_WORD, 32'h0, 1'b0, 1);
        add(K_WRITE, 32'h2000_0100, HSIZE_WORD, $random(seed), 1'b0, 2);
        add(K_WRITE, 32'h2000_0101, HSIZE_BYTE, $random(seed), 1'b0, 2);
        add(K_WRITE, 32'h2000_0102, HSIZE_HALF, $random(seed), 1'b0, 2);
        add(K_WRITE, 32'h0000_0202, HSIZE_HALF, $random(seed), 1'b0, 2);
        add(K_WRITE, 32'h0000_0200, HSIZE_BYTE, $random(seed), 1'b0, 2);
        add(K_READ,  32'h2000_0100, HSIZE_WORD, 32'h0, 1'b0, 2);
        add(K_READ,  32'h0000_0200, HSIZE_WORD, 32'h0, 1'b0, 2);
        add(K_WRITE, 32'h0000_0400, HSIZE_WORD, $random(seed), 1'b0, 3);
        add(K_READ,  32'h0000_0400, HSIZE_WORD, 32'h0, 1'b0, 3);
        add(K_WRITE, 32'h2000_0201, HSIZE_BYTE, $random(seed), 1'b0, 3);
        add(K_READ,  32'h2000_0200, HSIZE_WORD, 32'h0, 1'b0, 3);
        add(K_WRITE, 32'h0000_0404, HSIZE_WORD, $random(seed), 1'b0, 3);
        add(K_READ,  32'h0000_0404, HSIZE_WORD, 32'h0, 1'b0, 3);
        add(K_READ,  32'h0000_0400, HSIZE_WORD, 32'h0, 1'b0, 3);
        add(K_WRITE, 32'h0000_0500, HSIZE_WORD, $random(seed), 1'b0, 4);
        add(K_READ,  32'h4000_0000, HSIZE_WORD, 32'h0, 1'b1, 4);
        add(K_WRITE, 32'h4000_0500, HSIZE_WORD, $random(seed), 1'b1, 4);
        add(K_READ,  32'hf000_0000, HSIZE_WORD, 32'h0, 1'b1, 4);
        add(K_READ,  32'h0000_0500, HSIZE_WORD, 32'h0, 1'b0, 4);
        add(K_WRITE, 32'h0000_0600, HSIZE_WORD, $random(seed), 1'b0, 5);
        add(K_IDLE,  32'h0000_0600, HSIZE_WORD, 32'h0, 1'b0, 5);
        add(K_WRITE, 32'h2000_0600, HSIZE_WORD, $random(seed), 1'b0, 5);
        add(K_IDLE,  32'h2000_0600, HSIZE_WORD, 32'h0, 1'b0, 5);
        add(K_IDLE,  32'h0000_0600, HSIZE_WORD, 32'h0, 1'b0, 5);
        add(K_READ,  32'h0000_0600, HSIZE_WORD, 32'h0, 1'b0, 5);
        add(K_IDLE,  32'h2000_0600, HSIZE_WORD, 32'h0, 1'b0, 5);
        add(K_READ,  32'h2000_0600, HSIZE_WORD, 32'h0, 1'b0, 5);
        add(K_IDLE,  32'h0000_0000, HSIZE_WORD, 32'h0, 1'b0, NUM_TESTS);
    endtask

    initial begin
        seed   = 32'h8a50c523;
        rst_n  = 1'b0;
        haddr  = 32'h0;
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
        hsize  = HSIZE_WORD;
        hwdata = 32'h0;
        dp     = make_entry(K_IDLE, 32'h0, HSIZE_WORD, 32'h0, 1'b0, 0);
        build_table();
        repeat (10) @(negedge clk);
        if (hready !== 1'b1) report_mismatch("hready", 1'b1, hready, 0);
        if (hresp !== 1'b0) report_mismatch("hresp", 1'b0, hresp, 0);
        if (hrdata !== 32'h0) report_mismatch("hrdata", 32'h0, hrdata, 0);
        rst_n = 1'b1;
        foreach (table_q[i]) begin
            issue(table_q[i]);
        end
        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== tcm_ram.sv ====
module tcm_ram #(
    parameter int WORDS = 4096
) (
    input  logic                     clk,
    input  logic                     cs,
    input  logic [$clog2(WORDS)-1:0] addr,
    input  logic [3:0]               be,
    input  logic [31:0]              wdata,
    output logic [31:0]              rdata
);

    logic [31:0] mem [WORDS];

    // Contents start cleared
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = 32'h0;
        end
    end

    always @(posedge clk) begin
        if (cs) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (cs) begin
            rdata <= mem[addr];
        end
    end

endmodule
